// File: compile.f
design/cpuPkg.sv
design/timingControl.sv
design/instructionDecoder.sv
design/addressUnit.sv
design/executeUnit.sv
design/cpuCore.sv
tb/memoryModel.sv
tb/cpuCoreTb.sv

// File: Bender.yml
package:
  name: cpuCore

sources:
  - design/cpuPkg.sv
  - design/timingControl.sv
  - design/instructionDecoder.sv
  - design/addressUnit.sv
  - design/executeUnit.sv
  - design/cpuCore.sv
  - target: test
    files:
      - tb/memoryModel.sv
      - tb/cpuCoreTb.sv

// File: tb/cpuCoreTb.sv
`default_nettype none

module cpuCoreTb;
    import cpuPkg::*;

    localparam logic [15:0] MARKER_ADDR = 16'h03FF;
    localparam int          RUN_LIMIT   = 3000;
    localparam int          HALT_WATCH  = 50;

    logic        clk;
    logic        nrst;
    logic        rdy;
    logic [7:0]  memRData;
    busReqT      busReq;
    logic        halted;

    logic [7:0]  image      [0:65535];
    logic [7:0]  modelMem   [0:65535];
    logic [15:0] expAddr    [0:63];
    logic [7:0]  expData    [0:63];
    logic [15:0] steadyAddr [0:63];
    logic [7:0]  steadyData [0:63];
    int          expCount;
    int          steadyCount;
    int          mismatches;
    int          failures;
    logic [15:0] loc;
    logic [16:0] lfsr;
    logic        firstSeen;

    cpuCore i_dut (
        .clk      (clk),
        .nrst     (nrst),
        .rdy      (rdy),
        .memRData (memRData),
        .busReq   (busReq),
        .halted   (halted)
    );

    memoryModel memory (
        .clk    (clk),
        .nrst   (nrst),
        .busReq (busReq),
        .rdata  (memRData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ########################################
    // stimulus helpers
    // ########################################

    function automatic logic [16:0] lfsrNext(input logic [16:0] state);
        // taps 17 and 14 give a maximal length sequence
        return {state[15:0], state[16] ^ state[13]};
    endfunction

    task automatic takeBit(output logic bitOut);
        lfsr   = lfsrNext(lfsr);
        bitOut = lfsr[0];
    endtask

    task automatic placeByte(input logic [7:0] value);
        image[loc] = value;
        loc        = loc + 16'd1;
    endtask

    task automatic twoByteInstr(input logic [7:0] code, input logic [7:0] arg);
        placeByte(code);
        placeByte(arg);
    endtask

    task automatic threeByteInstr(input logic [7:0] code, input logic [15:0] addr);
        placeByte(code);
        placeByte(addr[7:0]);
        placeByte(addr[15:8]);
    endtask

    task automatic buildImage();
        int i;
        for (i = 0; i < 65536; i++) begin
            image[i] = i[15:8] ^ {i[4:0], i[7:5]} ^ 8'h69;
        end
        loc = 16'h0000;
        threeByteInstr(8'h4C, 16'h0400);
        loc = 16'h0400;
        // loads and stores in every mode where two of the zero page X forms wrap
        twoByteInstr(8'hA9, 8'h3C);
        twoByteInstr(8'h85, 8'h40);
        twoByteInstr(8'hA2, 8'h05);
        twoByteInstr(8'h95, 8'h40);
        twoByteInstr(8'hA5, 8'h80);
        threeByteInstr(8'h8D, 16'h0300);
        twoByteInstr(8'hB5, 8'h7B);
        threeByteInstr(8'h8D, 16'h0301);
        threeByteInstr(8'hAD, 16'h1234);
        twoByteInstr(8'h85, 8'h41);
        twoByteInstr(8'hA6, 8'h40);
        placeByte(8'hE8);
        twoByteInstr(8'h95, 8'hC8);
        threeByteInstr(8'hAE, 16'h0301);
        twoByteInstr(8'hB5, 8'hF7);
        twoByteInstr(8'h85, 8'h42);
        // carry chain through ADC
        placeByte(8'h18);
        twoByteInstr(8'hA9, 8'hF0);
        twoByteInstr(8'h69, 8'h20);
        twoByteInstr(8'h85, 8'h43);
        twoByteInstr(8'hA9, 8'h00);
        twoByteInstr(8'h69, 8'h00);
        twoByteInstr(8'h85, 8'h44);
        placeByte(8'h38);
        twoByteInstr(8'h65, 8'h43);
        twoByteInstr(8'h75, 8'h10);
        threeByteInstr(8'h6D, 16'h1234);
        threeByteInstr(8'h8D, 16'h0302);
        // logic operations
        twoByteInstr(8'h29, 8'h0F);
        twoByteInstr(8'h25, 8'h41);
        twoByteInstr(8'h09, 8'hA0);
        twoByteInstr(8'h15, 8'h20);
        threeByteInstr(8'h0D, 16'h0300);
        twoByteInstr(8'h49, 8'hFF);
        twoByteInstr(8'h45, 8'h42);
        twoByteInstr(8'h55, 8'h30);
        threeByteInstr(8'h4D, 16'h0301);
        threeByteInstr(8'h2D, 16'h0302);
        twoByteInstr(8'h95, 8'h00);
        // the jump skips a store of the marker
        threeByteInstr(8'h4C, 16'h0500);
        twoByteInstr(8'hA9, 8'hEE);
        threeByteInstr(8'h8D, MARKER_ADDR);
        loc = 16'h0500;
        placeByte(8'hFF);
        placeByte(8'hEA);
        twoByteInstr(8'h85, 8'h47);
        placeByte(8'h02);
    endtask

    // ########################################
    // reference model
    // ########################################

    // kinds follow the 6502 group one column with 1 ORA, 2 AND, 3 EOR, 4 ADC, 5 STA, 6 LDA
    // then 7 LDX, 8 INX, 9 CLC, 10 SEC, 11 JMP, and 0 for anything run as NOP
    task automatic predictWrites();
        logic [15:0] pc;
        logic [15:0] ea;
        logic [7:0]  op;
        logic [7:0]  a;
        logic [7:0]  x;
        logic [7:0]  data;
        logic [7:0]  zp;
        logic        c;
        int          total;
        int          kind;
        int          amode;
        int          steps;
        int          i;
        for (i = 0; i < 65536; i++) begin
            modelMem[i] = image[i];
        end
        pc       = RESET_PC;
        ea       = 16'h0000;
        a        = 8'h00;
        x        = 8'h00;
        c        = 1'b0;
        data     = 8'h00;
        expCount = 0;
        steps    = 0;
        op       = modelMem[pc];
        while (op != 8'h02 && steps < 500) begin
            kind  = 0;
            amode = 0;
            // amode 1 immediate, 2 zero page, 3 zero page X, 4 absolute
            if (op[1:0] == 2'b01 && op[7:5] <= 3'd5) begin
                case (op[4:2])
                    3'b010:  amode = 1;
                    3'b001:  amode = 2;
                    3'b101:  amode = 3;
                    3'b011:  amode = 4;
                    default: amode = 0;
                endcase
                if (amode != 0 && !(op[7:5] == 3'd4 && amode == 1)) begin
                    kind = int'(op[7:5]) + 1;
                end else begin
                    amode = 0;
                end
            end else if (op == 8'hA2 || op == 8'hA6 || op == 8'hAE) begin
                kind  = 7;
                amode = (op == 8'hA2) ? 1 : ((op == 8'hA6) ? 2 : 4);
            end else begin
                case (op)
                    8'hE8:   kind = 8;
                    8'h18:   kind = 9;
                    8'h38:   kind = 10;
                    8'h4C:   kind = 11;
                    default: kind = 0;
                endcase
                if (kind == 11) begin
                    amode = 4;
                end
            end
            pc = pc + 16'd1;
            if (amode >= 1 && amode <= 3) begin
                data = modelMem[pc];
                zp   = (amode == 3) ? data + x : data;
                ea   = {8'h00, zp};
                pc   = pc + 16'd1;
            end else if (amode == 4) begin
                ea = {modelMem[pc + 16'd1], modelMem[pc]};
                pc = pc + 16'd2;
            end
            if (amode >= 2 && kind != 5 && kind != 11) begin
                data = modelMem[ea];
            end
            case (kind)
                1: a = a | data;
                2: a = a & data;
                3: a = a ^ data;
                4: begin
                    total = int'(a) + int'(data) + int'(c);
                    c     = (total > 255);
                    a     = total[7:0];
                end
                5: begin
                    modelMem[ea] = a;
                    if (expCount < 64) begin
                        expAddr[expCount] = ea;
                        expData[expCount] = a;
                        expCount++;
                    end
                end
                6: a = data;
                7: x = data;
                8: x = x + 8'd1;
                9: c = 1'b0;
                10: c = 1'b1;
                11: pc = ea;
                default: ;
            endcase
            op = modelMem[pc];
            steps++;
        end
    endtask

    // ########################################
    // runs and checks
    // ########################################

    task automatic runCore(input logic stall);
        int   cycles;
        int   i;
        logic b0;
        logic b1;
        nrst      = 1'b0;
        rdy       = 1'b1;
        firstSeen = 1'b0;
        for (i = 0; i < 65536; i++) begin
            memory.ram[i] = image[i];
        end
        repeat (10) @(negedge clk);
        nrst   = 1'b1;
        cycles = 0;
        while (!halted && cycles < RUN_LIMIT) begin
            if (stall) begin
                takeBit(b0);
                takeBit(b1);
                // low in about one cycle out of four
                rdy = !(b0 && b1);
            end
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            failures++;
            $display("the core did not halt within %0d cycles", RUN_LIMIT);
        end else begin
            rdy = 1'b1;
            for (i = 0; i < HALT_WATCH; i++) begin
                @(posedge clk);
                assert (halted && !busReq.read && !busReq.write) else begin
                    mismatches++;
                    $display("mismatch at %0t: after HLT halted %b read %b write %b",
                             $time, halted, busReq.read, busReq.write);
                end
            end
            @(negedge clk);
        end
    endtask

    task automatic checkWrites(input string label);
        int i;
        assert (memory.writeCount == expCount) else begin
            mismatches++;
            $display("mismatch at %0t: %s run made %0d writes, expected %0d",
                     $time, label, memory.writeCount, expCount);
        end
        for (i = 0; i < expCount && i < memory.writeCount; i++) begin
            assert (memory.wrAddr[i] == expAddr[i] && memory.wrData[i] == expData[i]) else begin
                mismatches++;
                $display("mismatch at %0t: %s write %0d was %h <- %h, expected %h <- %h",
                         $time, label, i, memory.wrAddr[i], memory.wrData[i],
                         expAddr[i], expData[i]);
            end
        end
    endtask

    task automatic keepSteadyLog();
        int i;
        steadyCount = (memory.writeCount < 64) ? memory.writeCount : 64;
        for (i = 0; i < steadyCount; i++) begin
            steadyAddr[i] = memory.wrAddr[i];
            steadyData[i] = memory.wrData[i];
        end
    endtask

    task automatic compareWithSteady();
        int i;
        assert (memory.writeCount == steadyCount) else begin
            mismatches++;
            $display("mismatch at %0t: stalled run made %0d writes, steady run %0d",
                     $time, memory.writeCount, steadyCount);
        end
        for (i = 0; i < steadyCount && i < memory.writeCount; i++) begin
            assert (memory.wrAddr[i] == steadyAddr[i] &&
                    memory.wrData[i] == steadyData[i]) else begin
                mismatches++;
                $display("mismatch at %0t: stalled write %0d differs from the steady run",
                         $time, i);
            end
        end
    endtask

    // bus rules that hold in every cycle out of reset
    always @(posedge clk) begin
        if (nrst) begin
            assert (rdy || !(busReq.read || busReq.write)) else begin
                failures++;
                $display("a bus strobe was issued at %0t while rdy was low", $time);
            end
            assert (!(busReq.write && busReq.addr == MARKER_ADDR)) else begin
                mismatches++;
                $display("mismatch at %0t: write to the skipped marker address %h",
                         $time, busReq.addr);
            end
            if (!firstSeen && (busReq.read || busReq.write)) begin
                firstSeen = 1'b1;
                assert (busReq.read && !busReq.write && busReq.addr == RESET_PC) else begin
                    mismatches++;
                    $display("mismatch at %0t: first strobe read %b write %b addr %h",
                             $time, busReq.read, busReq.write, busReq.addr);
                end
            end
        end
    end

    initial begin
        nrst        = 1'b0;
        rdy         = 1'b1;
        lfsr        = 17'd88258;
        mismatches  = 0;
        failures    = 0;
        steadyCount = 0;
        buildImage();
        predictWrites();
        runCore(1'b0);
        checkWrites("steady");
        keepSteadyLog();
        runCore(1'b1);
        checkWrites("stalled");
        compareWithSteady();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/memoryModel.sv
`default_nettype none

module memoryModel (
    input  logic           clk,
    input  logic           nrst,
    input  cpuPkg::busReqT busReq,
    output logic [7:0]     rdata
);

    // the testbench fills ram before it releases reset
    logic [7:0]  ram    [0:65535];
    logic [15:0] wrAddr [0:63];
    logic [7:0]  wrData [0:63];
    int          writeCount;

    // ########################################
    // strobe handling
    // ########################################

    // a read answers one cycle later and holds until the next read
    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rdata      <= 8'h00;
            writeCount <= 0;
        end else begin
            if (busReq.read) begin
                rdata <= ram[busReq.addr];
            end
            if (busReq.write) begin
                ram[busReq.addr] <= busReq.wdata;
                // the log keeps the first 64 writes, the count keeps going
                if (writeCount < 64) begin
                    wrAddr[writeCount] <= busReq.addr;
                    wrData[writeCount] <= busReq.wdata;
                end
                writeCount <= writeCount + 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/cpuCore.sv
`default_nettype none

module cpuCore (
    input  logic           clk,
    input  logic           nrst,
    input  logic           rdy,
    input  logic [7:0]     memRData,
    output cpuPkg::busReqT busReq,
    output logic           halted
);
    import cpuPkg::*;

    decodedT   decoded;
    decodedT   current;
    cpuModeT   mode;
    timeStateT timeState;
    logic      noAddressing;
    logic      endAddressing;
    logic      getInstruction;
    logic [7:0]  operand;
    logic [15:0] effAddr;
    logic [7:0]  xIndex;
    execReqT   execReq;

    // ########################################
    // sequencing
    // ########################################

    // rdy is the single stall, it freezes every block at once
    timingControl i_timing (
        .clk            (clk),
        .nrst           (nrst),
        .enableFFs      (rdy),
        .noAddressing   (noAddressing),
        .endAddressing  (endAddressing),
        .getInstruction (getInstruction),
        .decoded        (decoded),
        .current        (current),
        .mode           (mode),
        .timeState      (timeState)
    );

    instructionDecoder i_decoder (
        .opcodeByte (memRData),
        .decoded    (decoded)
    );

    // ########################################
    // datapath
    // ########################################

    addressUnit i_address (
        .clk           (clk),
        .nrst          (nrst),
        .enableFFs     (rdy),
        .mode          (mode),
        .timeState     (timeState),
        .addrMode      (current.addrMode),
        .xIndex        (xIndex),
        .memRData      (memRData),
        .execReq       (execReq),
        .noAddressing  (noAddressing),
        .endAddressing (endAddressing),
        .operand       (operand),
        .effAddr       (effAddr),
        .busReq        (busReq)
    );

    executeUnit i_execute (
        .clk            (clk),
        .nrst           (nrst),
        .enableFFs      (rdy),
        .mode           (mode),
        .timeState      (timeState),
        .current        (current),
        .operand        (operand),
        .effAddr        (effAddr),
        .memRData       (memRData),
        .execReq        (execReq),
        .getInstruction (getInstruction),
        .xIndex         (xIndex),
        .halted         (halted)
    );

endmodule

`default_nettype wire

// File: design/executeUnit.sv
`default_nettype none

module executeUnit (
    input  logic               clk,
    input  logic               nrst,
    input  logic               enableFFs,
    input  cpuPkg::cpuModeT    mode,
    input  cpuPkg::timeStateT  timeState,
    input  cpuPkg::decodedT    current,
    input  logic [7:0]         operand,
    input  logic [15:0]        effAddr,
    input  logic [7:0]         memRData,
    output cpuPkg::execReqT    execReq,
    output logic               getInstruction,
    output logic [7:0]         xIndex,
    output logic               halted
);
    import cpuPkg::*;

    logic [7:0] acc;
    logic [7:0] xReg;
    logic       zFlag;
    logic       nFlag;
    logic       cFlag;
    logic [7:0] accNext;
    logic [7:0] xNext;
    logic       cNext;
    logic [7:0] result;
    logic       setZN;
    logic [8:0] sum;
    logic [7:0] data;
    logic       inInstr;
    logic       isDataOp;
    logic       memDataOp;
    logic       longOp;
    logic       isHalt;
    logic       applyStep;
    timeStateT  applyState;
    timeStateT  fetchState;
    timeStateT  doneState;

    // ########################################
    // step scheduling
    // ########################################

    assign inInstr   = (mode == INSTRUCTION);
    assign isHalt    = (current.opcode == HLT);
    assign isDataOp  = current.opcode inside {LDA, ADC, AND, ORA, EOR, LDX};
    assign memDataOp = isDataOp && (current.addrMode inside {ZEROPAGE, ZEROPAGE_X, ABSOLUTE});

    // memory reads and stores need one extra step before the fetch
    assign longOp     = memDataOp || (current.opcode == STA);
    assign applyState = memDataOp ? T1 : T0;
    assign fetchState = longOp ? T1 : T0;
    assign doneState  = longOp ? T2 : T1;

    assign applyStep      = inInstr && (timeState == applyState);
    assign getInstruction = inInstr && !isHalt && (timeState == doneState);
    assign data           = memDataOp ? memRData : operand;
    assign xIndex         = xReg;

    always_comb begin
        execReq = '0;
        if (inInstr) begin
            if (memDataOp && (timeState == T0)) begin
                execReq.read = 1'b1;
                execReq.addr = effAddr;
            end
            if ((current.opcode == STA) && (timeState == T0)) begin
                execReq.write = 1'b1;
                execReq.addr  = effAddr;
                execReq.wdata = acc;
            end
            if (!isHalt && (timeState == fetchState)) begin
                execReq.fetch = 1'b1;
                execReq.jump  = (current.opcode == JMP);
                execReq.addr  = effAddr;
            end
        end
    end

    // ########################################
    // result logic
    // ########################################

    always_comb begin
        accNext = acc;
        xNext   = xReg;
        cNext   = cFlag;
        setZN   = 1'b1;
        sum     = {1'b0, acc} + {1'b0, data} + {8'h00, cFlag};
        case (current.opcode)
            LDA: accNext = data;
            AND: accNext = acc & data;
            ORA: accNext = acc | data;
            EOR: accNext = acc ^ data;
            LDX: xNext = data;
            INX: xNext = xReg + 8'd1;
            ADC: begin
                accNext = sum[7:0];
                cNext   = sum[8];
            end
            CLC: begin
                cNext = 1'b0;
                setZN = 1'b0;
            end
            SEC: begin
                cNext = 1'b1;
                setZN = 1'b0;
            end
            default: setZN = 1'b0;
        endcase
        // Z and N follow whichever register the instruction wrote
        result = (current.opcode inside {LDX, INX}) ? xNext : accNext;
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            acc    <= 8'h00;
            xReg   <= 8'h00;
            zFlag  <= 1'b0;
            nFlag  <= 1'b0;
            cFlag  <= 1'b0;
            halted <= 1'b0;
        end else if (enableFFs && applyStep) begin
            acc   <= accNext;
            xReg  <= xNext;
            cFlag <= cNext;
            if (setZN) begin
                zFlag <= (result == 8'h00);
                nFlag <= result[7];
            end
            // once set, nothing clears it short of reset
            if (isHalt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/addressUnit.sv
`default_nettype none

module addressUnit (
    input  logic               clk,
    input  logic               nrst,
    input  logic               enableFFs,
    input  cpuPkg::cpuModeT    mode,
    input  cpuPkg::timeStateT  timeState,
    input  cpuPkg::addrModeT   addrMode,
    input  logic [7:0]         xIndex,
    input  logic [7:0]         memRData,
    input  cpuPkg::execReqT    execReq,
    output logic               noAddressing,
    output logic               endAddressing,
    output logic [7:0]         operand,
    output logic [15:0]        effAddr,
    output cpuPkg::busReqT     busReq
);
    import cpuPkg::*;

    logic [15:0] pc;
    logic [15:0] pcNext;
    logic [7:0]  lowByte;
    logic [7:0]  zpIndexed;
    logic        inAddress;
    logic        operandRead;

    assign inAddress    = (mode == ADDRESS);
    assign noAddressing = inAddress && (timeState == T0) && (addrMode == IMPLIED);
    // zero page X stays inside page 0, the carry is dropped
    assign zpIndexed    = memRData + xIndex;

    // operand bytes are read at T0, and absolute reads its high byte at T1
    assign operandRead = inAddress &&
                         (((timeState == T0) && (addrMode != IMPLIED)) ||
                          ((timeState == T1) && (addrMode == ABSOLUTE)));

    always_comb begin
        case (addrMode)
            IMMEDIATE, ZEROPAGE, ZEROPAGE_X: endAddressing = inAddress && (timeState == T1);
            ABSOLUTE:                        endAddressing = inAddress && (timeState == T2);
            default:                         endAddressing = 1'b0;
        endcase
    end

    // ########################################
    // memory bus and program counter
    // ########################################

    always_comb begin
        busReq = '0;
        pcNext = pc;
        if (inAddress) begin
            if (operandRead) begin
                busReq.read = 1'b1;
                busReq.addr = pc;
                pcNext      = pc + 16'd1;
            end
        end else if (execReq.fetch) begin
            busReq.read = 1'b1;
            busReq.addr = execReq.jump ? execReq.addr : pc;
            pcNext      = busReq.addr + 16'd1;
        end else begin
            busReq.read  = execReq.read;
            busReq.write = execReq.write;
            busReq.addr  = execReq.addr;
            busReq.wdata = execReq.wdata;
        end
        // a stalled cycle must not touch memory
        if (!enableFFs) begin
            busReq.read  = 1'b0;
            busReq.write = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pc <= RESET_PC;
        end else if (enableFFs) begin
            pc <= pcNext;
        end
    end

    // ########################################
    // operand and effective address
    // ########################################

    always_ff @(posedge clk) begin
        if (enableFFs && inAddress) begin
            case (addrMode)
                IMMEDIATE: begin
                    if (timeState == T1) begin
                        operand <= memRData;
                    end
                end
                ZEROPAGE: begin
                    if (timeState == T1) begin
                        effAddr <= {ZERO_PAGE_HIGH, memRData};
                    end
                end
                ZEROPAGE_X: begin
                    if (timeState == T1) begin
                        effAddr <= {ZERO_PAGE_HIGH, zpIndexed};
                    end
                end
                ABSOLUTE: begin
                    // low byte arrives first, the high byte one step later
                    if (timeState == T1) begin
                        lowByte <= memRData;
                    end
                    if (timeState == T2) begin
                        effAddr <= {memRData, lowByte};
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/instructionDecoder.sv
`default_nettype none

module instructionDecoder (
    input  logic [7:0]      opcodeByte,
    output cpuPkg::decodedT decoded
);
    import cpuPkg::*;

    // pure table lookup, the timing block decides when to latch it
    always_comb begin
        case (opcodeByte)
            OP_LDA_IMM: decoded = '{LDA, IMMEDIATE};
            OP_LDA_ZP:  decoded = '{LDA, ZEROPAGE};
            OP_LDA_ZPX: decoded = '{LDA, ZEROPAGE_X};
            OP_LDA_ABS: decoded = '{LDA, ABSOLUTE};
            OP_STA_ZP:  decoded = '{STA, ZEROPAGE};
            OP_STA_ZPX: decoded = '{STA, ZEROPAGE_X};
            OP_STA_ABS: decoded = '{STA, ABSOLUTE};
            OP_ADC_IMM: decoded = '{ADC, IMMEDIATE};
            OP_ADC_ZP:  decoded = '{ADC, ZEROPAGE};
            OP_ADC_ZPX: decoded = '{ADC, ZEROPAGE_X};
            OP_ADC_ABS: decoded = '{ADC, ABSOLUTE};
            OP_AND_IMM: decoded = '{AND, IMMEDIATE};
            OP_AND_ZP:  decoded = '{AND, ZEROPAGE};
            OP_AND_ZPX: decoded = '{AND, ZEROPAGE_X};
            OP_AND_ABS: decoded = '{AND, ABSOLUTE};
            OP_ORA_IMM: decoded = '{ORA, IMMEDIATE};
            OP_ORA_ZP:  decoded = '{ORA, ZEROPAGE};
            OP_ORA_ZPX: decoded = '{ORA, ZEROPAGE_X};
            OP_ORA_ABS: decoded = '{ORA, ABSOLUTE};
            OP_EOR_IMM: decoded = '{EOR, IMMEDIATE};
            OP_EOR_ZP:  decoded = '{EOR, ZEROPAGE};
            OP_EOR_ZPX: decoded = '{EOR, ZEROPAGE_X};
            OP_EOR_ABS: decoded = '{EOR, ABSOLUTE};
            OP_LDX_IMM: decoded = '{LDX, IMMEDIATE};
            OP_LDX_ZP:  decoded = '{LDX, ZEROPAGE};
            OP_LDX_ABS: decoded = '{LDX, ABSOLUTE};
            OP_INX:     decoded = '{INX, IMPLIED};
            OP_CLC:     decoded = '{CLC, IMPLIED};
            OP_SEC:     decoded = '{SEC, IMPLIED};
            OP_JMP_ABS: decoded = '{JMP, ABSOLUTE};
            OP_HLT:     decoded = '{HLT, IMPLIED};
            // everything else, the real NOP included, runs as a one-step NOP
            default:    decoded = '{NOP, IMPLIED};
        endcase
    end

endmodule

`default_nettype wire

// File: design/timingControl.sv
`default_nettype none

module timingControl (
    input  logic               clk,
    input  logic               nrst,
    input  logic               enableFFs,
    input  logic               noAddressing,
    input  logic               endAddressing,
    input  logic               getInstruction,
    input  cpuPkg::decodedT    decoded,
    output cpuPkg::decodedT    current,
    output cpuPkg::cpuModeT    mode,
    output cpuPkg::timeStateT  timeState
);
    import cpuPkg::*;

    cpuModeT   nextMode;
    timeStateT nextTime;
    decodedT   nextCurrent;

    // ########################################
    // next mode and time state
    // ########################################

    always_comb begin
        nextCurrent = current;
        if (endAddressing || noAddressing) begin
            // addressing is done, so the instruction starts over at T0
            nextMode = INSTRUCTION;
            nextTime = T0;
        end else if (getInstruction) begin
            // the new opcode is on the data bus this cycle
            nextMode    = ADDRESS;
            nextTime    = T0;
            nextCurrent = decoded;
        end else begin
            nextMode = mode;
            if (timeState == T6) begin
                nextTime = T0;
            end else begin
                nextTime = timeStateT'(timeState + 3'd1);
            end
        end
    end

    // ########################################
    // state registers
    // ########################################

    // a low enable holds mode, time state and the latched instruction
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            mode      <= ADDRESS;
            timeState <= T0;
            current   <= '{NOP, IMPLIED};
        end else if (enableFFs) begin
            mode      <= nextMode;
            timeState <= nextTime;
            current   <= nextCurrent;
        end
    end

endmodule

`default_nettype wire

// File: design/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // ########################################
    // instruction kinds and addressing modes
    // ########################################

    typedef enum logic [5:0] {
        NOP = 6'd0,
        LDA,
        STA,
        ADC,
        AND,
        ORA,
        EOR,
        LDX,
        INX,
        CLC,
        SEC,
        JMP,
        HLT
    } opcodeT;

    typedef enum logic [3:0] {
        IMPLIED = 4'd0,
        IMMEDIATE,
        ZEROPAGE,
        ZEROPAGE_X,
        ABSOLUTE
    } addrModeT;

    // the core alternates between forming an address and executing
    typedef enum logic {
        ADDRESS,
        INSTRUCTION
    } cpuModeT;

    typedef enum logic [2:0] {
        T0, T1, T2, T3, T4, T5, T6
    } timeStateT;

    // ########################################
    // bundles passed between blocks
    // ########################################

    typedef struct packed {
        opcodeT   opcode;
        addrModeT addrMode;
    } decodedT;

    typedef struct packed {
        logic        read;
        logic        write;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } busReqT;

    // fetch reads at PC unless jump is set, then it reads at addr
    typedef struct packed {
        logic        read;
        logic        write;
        logic        fetch;
        logic        jump;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } execReqT;

    localparam logic [15:0] RESET_PC       = 16'h0000;
    localparam logic [7:0]  ZERO_PAGE_HIGH = 8'h00;

    // 6502 opcode bytes of the supported subset
    localparam logic [7:0] OP_LDA_IMM = 8'hA9;
    localparam logic [7:0] OP_LDA_ZP  = 8'hA5;
    localparam logic [7:0] OP_LDA_ZPX = 8'hB5;
    localparam logic [7:0] OP_LDA_ABS = 8'hAD;
    localparam logic [7:0] OP_STA_ZP  = 8'h85;
    localparam logic [7:0] OP_STA_ZPX = 8'h95;
    localparam logic [7:0] OP_STA_ABS = 8'h8D;
    localparam logic [7:0] OP_ADC_IMM = 8'h69;
    localparam logic [7:0] OP_ADC_ZP  = 8'h65;
    localparam logic [7:0] OP_ADC_ZPX = 8'h75;
    localparam logic [7:0] OP_ADC_ABS = 8'h6D;
    localparam logic [7:0] OP_AND_IMM = 8'h29;
    localparam logic [7:0] OP_AND_ZP  = 8'h25;
    localparam logic [7:0] OP_AND_ZPX = 8'h35;
    localparam logic [7:0] OP_AND_ABS = 8'h2D;
    localparam logic [7:0] OP_ORA_IMM = 8'h09;
    localparam logic [7:0] OP_ORA_ZP  = 8'h05;
    localparam logic [7:0] OP_ORA_ZPX = 8'h15;
    localparam logic [7:0] OP_ORA_ABS = 8'h0D;
    localparam logic [7:0] OP_EOR_IMM = 8'h49;
    localparam logic [7:0] OP_EOR_ZP  = 8'h45;
    localparam logic [7:0] OP_EOR_ZPX = 8'h55;
    localparam logic [7:0] OP_EOR_ABS = 8'h4D;
    localparam logic [7:0] OP_LDX_IMM = 8'hA2;
    localparam logic [7:0] OP_LDX_ZP  = 8'hA6;
    localparam logic [7:0] OP_LDX_ABS = 8'hAE;
    localparam logic [7:0] OP_INX     = 8'hE8;
    localparam logic [7:0] OP_CLC     = 8'h18;
    localparam logic [7:0] OP_SEC     = 8'h38;
    localparam logic [7:0] OP_JMP_ABS = 8'h4C;
    localparam logic [7:0] OP_NOP     = 8'hEA;
    localparam logic [7:0] OP_HLT     = 8'h02;

endpackage

`default_nettype wire
